//--- dv/fetch_mem_cases.txt
# op addr data expected, all hex; S store, L load, F fetch,
# X fetch at addr while a load of the address in the data column is pending
# stores come first, while the fetch address is parked away from these lines
S 0200 c3c3000000000200 0
L 0200 0 c3c3000000000200
S 0080 a5a5000000000080 0
S 0088 a5a5000000000088 0
S 0090 a5a5000000000090 0
S 0098 a5a5000000000098 0
S 00a0 a5a50000000000a0 0
S 0180 5a5a000000000180 0
S 0300 3c3c000000000300 0
S 0400 0f0f000000000400 0
L 0080 0 a5a5000000000080
# first fetch restarts the window, the next ones come from the prefetch
F 0080 0 a5a5000000000080
F 0088 0 a5a5000000000088
F 0090 0 a5a5000000000090
F 0098 0 a5a5000000000098
F 00a0 0 a5a50000000000a0
F 0084 0 a5a5000000000080
# same index, other tag, then back again
F 0180 0 5a5a000000000180
F 0080 0 a5a5000000000080
X 0400 0300 0f0f000000000400
L 0098 0 a5a5000000000098
F 0098 0 a5a5000000000098
X 0090 0200 a5a5000000000090
L 0300 0 3c3c000000000300

//--- dv/fetch_mem_tb.sv
`timescale 1ns/10ps

module fetch_mem_tb
  import mem_pkg::*;
();

  localparam int WAIT_LIMIT = 200;
  // fetch address parked on a tag that no case uses while the stores run.
  localparam logic [15:0] PARK_ADDR = 16'h8000;

  logic        clock;
  logic        reset;
  logic [15:0] fetch_addr;
  mem_req_t    dp_req;
  logic [63:0] icache_data;
  logic        icache_valid;
  logic [63:0] dp_rdata;
  logic        dp_done;
  logic        dp_busy;

  // words written by store cases, keyed by byte address.
  logic [63:0] stored [logic [15:0]];
  int          errors;
  int          cases_run;
  int          cases_failed;

  fetch_mem_top i_dut (
    .i_clock        (clock),
    .i_reset        (reset),
    .i_fetch_addr   (fetch_addr),
    .i_dp_req       (dp_req),
    .o_icache_data  (icache_data),
    .o_icache_valid (icache_valid),
    .o_dp_rdata     (dp_rdata),
    .o_dp_done      (dp_done),
    .o_dp_busy      (dp_busy)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #2 clock = ~clock;
    end
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at time %0t: %s, got %h, expected %h",
               $time, what, actual, expected);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // data port and fetch sequences.
  ////////////////////////////////////////////////////////////

  // request is held until done pulses, then dropped.
  task automatic dp_access(input bus_cmd_t cmd, input logic [15:0] addr,
                           input logic [63:0] data, input logic [63:0] expected);
    int n;
    n = 0;
    dp_req.cmd  = cmd;
    dp_req.addr = addr;
    dp_req.data = data;
    do begin
      @(negedge clock);
      n++;
    end while (!dp_done && n < WAIT_LIMIT);
    dp_req.cmd = BUS_NONE;
    if (!dp_done) begin
      $display("timeout: data port access at %h did not finish in %0d cycles",
               addr, WAIT_LIMIT);
      errors++;
    end else if (cmd == BUS_LOAD) begin
      check_value(dp_rdata, expected, $sformatf("load data at %h", addr));
    end
  endtask

  task automatic fetch_line(input logic [15:0] addr, input logic [63:0] expected);
    int n;
    n = 0;
    fetch_addr = addr;
    do begin
      @(negedge clock);
      n++;
    end while (!icache_valid && n < WAIT_LIMIT);
    if (icache_valid) begin
      check_value(icache_data, expected, $sformatf("fetch data at %h", addr));
    end else begin
      $display("timeout: fetch at %h never became valid in %0d cycles", addr, WAIT_LIMIT);
      errors++;
    end
  endtask

  // the fetch starts only once the load is out on the bus.
  task automatic fetch_during_load(input logic [15:0] addr, input logic [15:0] load_addr,
                                   input logic [63:0] expected);
    int   n;
    logic fetch_seen;
    logic load_seen;
    n          = 0;
    fetch_seen = 1'b0;
    load_seen  = 1'b0;
    dp_req.cmd  = BUS_LOAD;
    dp_req.addr = load_addr;
    dp_req.data = 64'h0;
    do begin
      @(negedge clock);
      n++;
    end while (!dp_busy && n < WAIT_LIMIT);
    if (!dp_busy) begin
      $display("timeout: load at %h never became pending", load_addr);
      errors++;
    end
    fetch_addr = addr;
    n = 0;
    do begin
      @(negedge clock);
      n++;
      if (icache_valid && !fetch_seen) begin
        fetch_seen = 1'b1;
        check_value(icache_data, expected, $sformatf("fetch data at %h", addr));
      end
      if (dp_done && !load_seen) begin
        load_seen  = 1'b1;
        dp_req.cmd = BUS_NONE;
        check_value(dp_rdata, stored[load_addr], $sformatf("load data at %h", load_addr));
      end
    end while (!(fetch_seen && load_seen) && n < WAIT_LIMIT);
    dp_req.cmd = BUS_NONE;
    if (!fetch_seen || !load_seen) begin
      $display("timeout: fetch at %h with load at %h did not both finish", addr, load_addr);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence.
  ////////////////////////////////////////////////////////////

  initial begin
    int                 fd;
    int                 code;
    int                 errors_before;
    logic [7:0]         op;
    logic [8*128-1:0]   rest_of_line;
    logic [15:0]        addr;
    logic [63:0]        data;
    logic [63:0]        expected;

    void'($urandom(84591));
    errors       = 0;
    cases_run    = 0;
    cases_failed = 0;
    reset        = 1'b1;
    fetch_addr   = PARK_ADDR;
    dp_req.cmd   = BUS_NONE;
    dp_req.addr  = 16'h0;
    dp_req.data  = 64'h0;

    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    errors_before = errors;
    check_value(64'(icache_valid), 64'h0, "icache valid after reset");
    check_value(64'(dp_done), 64'h0, "data port done after reset");
    check_value(64'(dp_busy), 64'h0, "data port busy after reset");
    $display("reset: %s", (errors == errors_before) ? "ok" : "FAILED");

    fd = $fopen("dv/fetch_mem_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file dv/fetch_mem_cases.txt");
      errors++;
    end
    while (fd != 0 && $fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        code = $fgets(rest_of_line, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h", addr, data, expected);
        cases_run++;
        errors_before = errors;
        if (code != 3) begin
          $display("malformed line in the cases file after operation %s", op);
          errors++;
        end else begin
          case (op)
            "S": begin
              stored[addr] = data;
              dp_access(BUS_STORE, addr, data, 64'h0);
            end
            "L": dp_access(BUS_LOAD, addr, 64'h0, expected);
            "F": fetch_line(addr, expected);
            "X": fetch_during_load(addr, data[15:0], expected);
            default: begin
              $display("unknown operation %s in the cases file", op);
              errors++;
            end
          endcase
        end
        if (errors != errors_before) begin
          cases_failed++;
        end
        $display("case %0d: %s %h %s", cases_run, op, addr,
                 (errors == errors_before) ? "ok" : "FAILED");
        repeat ($urandom_range(0, 3)) @(negedge clock);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (cases_run == 0) begin
      $display("no cases were read from the cases file");
      errors++;
    end

    $display("summary: %0d cases, %0d passed, %0d failed, %0d check errors",
             cases_run, cases_run - cases_failed, cases_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hdl/mem_pkg.sv
hdl/icache.sv
hdl/data_port.sv
hdl/mem_arbiter.sv
hdl/tagged_memory.sv
hdl/fetch_mem_top.sv
dv/fetch_mem_tb.sv

//--- hdl/data_port.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module data_port
  import mem_pkg::*;
(
  input  logic                 i_clock,
  input  logic                 i_reset,
  input  mem_req_t             i_dp_req,
  input  logic [MEM_TAG_W-1:0] i_mem_response,
  input  logic [MEM_TAG_W-1:0] i_mem_tag,
  input  logic [63:0]          i_mem_data,
  output mem_req_t             o_mem_req,
  output logic [63:0]          o_dp_rdata,
  output logic                 o_dp_done,
  output logic                 o_dp_busy
);

  logic                 load_wait;
  logic                 done_q;
  logic [MEM_TAG_W-1:0] load_tag;
  logic                 accepted;
  logic                 returned;

  // hold off the bus while a load is out and in the done cycle.
  always_comb begin
    o_mem_req = i_dp_req;
    if (load_wait || done_q) begin
      o_mem_req.cmd = BUS_NONE;
    end
  end

  assign accepted = i_mem_response != '0;
  assign returned = load_wait && (i_mem_tag == load_tag);

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      load_wait <= `FALSE;
      done_q    <= `FALSE;
      load_tag  <= '0;
    end else begin
      done_q <= `FALSE;
      if (accepted && (o_mem_req.cmd == BUS_STORE)) begin
        done_q <= `TRUE;
      end
      if (accepted && (o_mem_req.cmd == BUS_LOAD)) begin
        load_wait <= `TRUE;
        load_tag  <= i_mem_response;
      end
      if (returned) begin
        load_wait <= `FALSE;
        done_q    <= `TRUE;
      end
    end
  end

  // load data register.
  always_ff @(posedge i_clock) begin
    if (returned) begin
      o_dp_rdata <= i_mem_data;
    end
  end

  assign o_dp_done = done_q;
  assign o_dp_busy = load_wait;

endmodule

//--- hdl/fetch_mem_top.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module fetch_mem_top
  import mem_pkg::*;
(
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic [15:0] i_fetch_addr,
  input  mem_req_t    i_dp_req,
  output logic [63:0] o_icache_data,
  output logic        o_icache_valid,
  output logic [63:0] o_dp_rdata,
  output logic        o_dp_done,
  output logic        o_dp_busy
);

  mem_req_t             ic_req;
  mem_req_t             dp_req;
  mem_req_t             mem_req;
  logic [MEM_TAG_W-1:0] mem_response;
  logic [MEM_TAG_W-1:0] dp_response;
  logic [MEM_TAG_W-1:0] ic_response;
  logic [MEM_TAG_W-1:0] ret_tag;
  logic [63:0]          ret_data;

  icache i_icache (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_fetch_addr   (i_fetch_addr),
    .i_mem_response (ic_response),
    .i_mem_tag      (ret_tag),
    .i_mem_data     (ret_data),
    .o_mem_req      (ic_req),
    .o_icache_data  (o_icache_data),
    .o_icache_valid (o_icache_valid)
  );

  data_port i_data_port (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_dp_req       (i_dp_req),
    .i_mem_response (dp_response),
    .i_mem_tag      (ret_tag),
    .i_mem_data     (ret_data),
    .o_mem_req      (dp_req),
    .o_dp_rdata     (o_dp_rdata),
    .o_dp_done      (o_dp_done),
    .o_dp_busy      (o_dp_busy)
  );

  mem_arbiter i_mem_arbiter (
    .i_dp_req       (dp_req),
    .i_ic_req       (ic_req),
    .i_mem_response (mem_response),
    .o_mem_req      (mem_req),
    .o_dp_response  (dp_response),
    .o_ic_response  (ic_response)
  );

  // return tag and data go to both requesters.
  tagged_memory i_tagged_memory (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_mem_req      (mem_req),
    .o_mem_response (mem_response),
    .o_mem_tag      (ret_tag),
    .o_mem_data     (ret_data)
  );

endmodule

//--- hdl/icache.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module icache
  import mem_pkg::*;
(
  input  logic                 i_clock,
  input  logic                 i_reset,
  input  logic [15:0]          i_fetch_addr,
  input  logic [MEM_TAG_W-1:0] i_mem_response,
  input  logic [MEM_TAG_W-1:0] i_mem_tag,
  input  logic [63:0]          i_mem_data,
  output mem_req_t             o_mem_req,
  output logic [63:0]          o_icache_data,
  output logic                 o_icache_valid
);

  localparam int LINE_W = ICACHE_TAG_W + ICACHE_IDX_W;

  icache_entry_t  [`NUM_ICACHE_LINES-1:0] lines, next_lines;
  mem_tag_entry_t [`NUM_MEM_TAGS-1:0]     tag_table, next_tag_table;
  logic [`NUM_MEM_TAGS-1:0]               tag_owned, next_tag_owned;
  bus_cmd_t                               cmd_q;

  logic [ICACHE_IDX_W-1:0] idx, head, tail, next_head, next_tail, req_idx;
  logic [ICACHE_IDX_W-1:0] fetch_off, tail_off, tail_inc;
  logic [ICACHE_TAG_W-1:0] tag, tail_tag, next_tail_tag, req_tag;
  logic [LINE_W-1:0]       req_line, req_line_inc;
  logic                    hit, in_window, pending, restart, full, issue, accepted;

  ////////////////////////////////////////////////////////////
  // lookup.
  ////////////////////////////////////////////////////////////

  assign idx = i_fetch_addr[3 +: ICACHE_IDX_W];
  assign tag = i_fetch_addr[15 -: ICACHE_TAG_W];

  assign hit            = lines[idx].valid && (lines[idx].tag == tag);
  assign o_icache_valid = hit;
  assign o_icache_data  = lines[idx].data;

  // lines head..tail-1 have been requested since the last restart.
  assign fetch_off = idx - head;
  assign tail_off  = tail - head;
  assign in_window = fetch_off < tail_off;
  assign pending   = in_window && (lines[idx].tag == tag);
  assign restart   = !hit && !pending;

  // one slot stays empty so a full window differs from an empty one.
  assign tail_inc = tail + 1'b1;
  assign full     = tail_inc == head;

  ////////////////////////////////////////////////////////////
  // request.
  ////////////////////////////////////////////////////////////

  assign req_idx      = restart ? idx : tail;
  assign req_tag      = restart ? tag : tail_tag;
  assign req_line     = {req_tag, req_idx};
  assign req_line_inc = req_line + 1'b1;
  assign issue        = restart || !full;
  assign accepted     = i_mem_response != '0;

  always_comb begin
    o_mem_req.cmd  = issue ? cmd_q : BUS_NONE;
    o_mem_req.addr = {req_tag, req_idx, 3'b000};
    o_mem_req.data = 64'h0;
  end

  always_comb begin
    next_head = head;
    {next_tail_tag, next_tail} = {tail_tag, tail};
    if (restart) begin
      next_head = idx;
      {next_tail_tag, next_tail} = {tag, idx};
    end
    // prefetch moves on past the line just requested.
    if (accepted) begin
      {next_tail_tag, next_tail} = req_line_inc;
    end
  end

  ////////////////////////////////////////////////////////////
  // tag table and fill.
  ////////////////////////////////////////////////////////////

  always_comb begin
    next_lines     = lines;
    next_tag_table = tag_table;
    next_tag_owned = tag_owned;
    if (accepted) begin
      next_lines[req_idx].tag              = req_tag;
      next_lines[req_idx].valid            = `FALSE;
      next_tag_table[i_mem_response].idx   = req_idx;
      next_tag_table[i_mem_response].tag   = req_tag;
      next_tag_owned[i_mem_response]       = `TRUE;
    end
    if (tag_owned[i_mem_tag]) begin
      next_tag_owned[i_mem_tag] = `FALSE;
      // drop data for a line that was retagged while the load was out.
      if (tag_table[i_mem_tag].tag == next_lines[tag_table[i_mem_tag].idx].tag) begin
        next_lines[tag_table[i_mem_tag].idx].valid = `TRUE;
        next_lines[tag_table[i_mem_tag].idx].data  = i_mem_data;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      lines     <= '0;
      head      <= '0;
      tail      <= '0;
      tail_tag  <= '0;
      tag_owned <= '0;
      cmd_q     <= BUS_NONE;
    end else begin
      lines     <= next_lines;
      head      <= next_head;
      tail      <= next_tail;
      tail_tag  <= next_tail_tag;
      tag_owned <= next_tag_owned;
      cmd_q     <= BUS_LOAD;
    end
  end

  always_ff @(posedge i_clock) begin
    tag_table <= next_tag_table;
  end

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_arbiter
  import mem_pkg::*;
(
  input  mem_req_t             i_dp_req,
  input  mem_req_t             i_ic_req,
  input  logic [MEM_TAG_W-1:0] i_mem_response,
  output mem_req_t             o_mem_req,
  output logic [MEM_TAG_W-1:0] o_dp_response,
  output logic [MEM_TAG_W-1:0] o_ic_response
);

  logic dp_grant;

  ////////////////////////////////////////////////////////////
  // fixed priority with the data port first.
  ////////////////////////////////////////////////////////////

  assign dp_grant = i_dp_req.cmd != BUS_NONE;

  always_comb begin
    if (dp_grant) begin
      o_mem_req = i_dp_req;
    end else begin
      o_mem_req = i_ic_req;
    end
  end

  // the loser sees a zero tag and holds its request.
  always_comb begin
    o_dp_response = '0;
    o_ic_response = '0;
    if (dp_grant) begin
      o_dp_response = i_mem_response;
    end else begin
      o_ic_response = i_mem_response;
    end
  end

endmodule

//--- hdl/mem_pkg.sv
`include "mem_params.svh"

package mem_pkg;

  // byte address is 16 bits, 3 offset bits select the byte in a line.
  localparam int ICACHE_IDX_W = $clog2(`NUM_ICACHE_LINES);
  localparam int ICACHE_TAG_W = 16 - 3 - ICACHE_IDX_W;
  localparam int MEM_TAG_W    = $clog2(`NUM_MEM_TAGS);

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_t;

  // one memory request, shared by both requesters.
  typedef struct packed {
    bus_cmd_t    cmd;
    logic [15:0] addr;
    logic [63:0] data;
  } mem_req_t;

  typedef struct packed {
    logic                    valid;
    logic [ICACHE_TAG_W-1:0] tag;
    logic [63:0]             data;
  } icache_entry_t;

  // line that an outstanding memory tag will fill.
  typedef struct packed {
    logic [ICACHE_IDX_W-1:0] idx;
    logic [ICACHE_TAG_W-1:0] tag;
  } mem_tag_entry_t;

endpackage

//--- hdl/tagged_memory.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module tagged_memory
  import mem_pkg::*;
(
  input  logic                 i_clock,
  input  logic                 i_reset,
  input  mem_req_t             i_mem_req,
  output logic [MEM_TAG_W-1:0] o_mem_response,
  output logic [MEM_TAG_W-1:0] o_mem_tag,
  output logic [63:0]          o_mem_data
);

  localparam int WORD_W = $clog2(`MEM_WORDS);

  logic [63:0]              mem [`MEM_WORDS];
  logic [MEM_TAG_W-1:0]     pipe_tag [`MEM_LATENCY];
  logic [63:0]              pipe_data [`MEM_LATENCY];
  logic [`NUM_MEM_TAGS-1:0] tag_free;
  logic [MEM_TAG_W-1:0]     alloc_tag;
  logic [WORD_W-1:0]        word;
  logic                     accept_load;
  logic                     accept_store;

  assign word = i_mem_req.addr[3 +: WORD_W];

  ////////////////////////////////////////////////////////////
  // tag allocation.
  ////////////////////////////////////////////////////////////

  // lowest free tag wins, tag 0 is never free.
  always_comb begin
    alloc_tag = '0;
    for (int t = `NUM_MEM_TAGS - 1; t > 0; t--) begin
      if (tag_free[t]) begin
        alloc_tag = MEM_TAG_W'(t);
      end
    end
  end

  assign o_mem_response = (i_mem_req.cmd != BUS_NONE) ? alloc_tag : '0;
  assign accept_load    = (o_mem_response != '0) && (i_mem_req.cmd == BUS_LOAD);
  assign accept_store   = (o_mem_response != '0) && (i_mem_req.cmd == BUS_STORE);

  ////////////////////////////////////////////////////////////
  // return pipeline.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      tag_free <= {{(`NUM_MEM_TAGS - 1){`TRUE}}, `FALSE};
      for (int s = 0; s < `MEM_LATENCY; s++) begin
        pipe_tag[s] <= '0;
      end
    end else begin
      // a store has no return, so its tag is never taken.
      if (o_mem_tag != '0) begin
        tag_free[o_mem_tag] <= `TRUE;
      end
      if (accept_load) begin
        tag_free[alloc_tag] <= `FALSE;
      end
      pipe_tag[0] <= accept_load ? alloc_tag : '0;
      for (int s = 1; s < `MEM_LATENCY; s++) begin
        pipe_tag[s] <= pipe_tag[s-1];
      end
    end
  end

  // word array and data stages.
  always_ff @(posedge i_clock) begin
    if (accept_store) begin
      mem[word] <= i_mem_req.data;
    end
    pipe_data[0] <= mem[word];
    for (int s = 1; s < `MEM_LATENCY; s++) begin
      pipe_data[s] <= pipe_data[s-1];
    end
  end

  assign o_mem_tag  = pipe_tag[`MEM_LATENCY-1];
  assign o_mem_data = pipe_data[`MEM_LATENCY-1];

endmodule

//--- include/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

////////////////////////////////////////////////////////////
// instruction cache geometry.
////////////////////////////////////////////////////////////

// direct-mapped lines of 64 bits each.
`define NUM_ICACHE_LINES 32

////////////////////////////////////////////////////////////
// memory model.
////////////////////////////////////////////////////////////

// 64-bit words.
`define MEM_WORDS        2048
`define MEM_LATENCY      6
// tag 0 is reserved to mean no tag.
`define NUM_MEM_TAGS     16

`define TRUE             1'b1
`define FALSE            1'b0

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the fetch memory testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f flist.f \
  --top-module fetch_mem_tb -o fetch_mem_sim
./obj_dir/fetch_mem_sim | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"
